// ==== cpu_pkg.sv ====
package cpu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_addr_t;
	typedef logic [3:0] strb_t;

	// boot rom base, first fetch after reset
	localparam word_t RESET_VECTOR = 32'hbfc0_0000;
	// return address register for jal
	localparam reg_addr_t REG_RA = 5'd31;

	// primary opcode field, inst[31:26]
	localparam logic [5:0] OP_SPECIAL = 6'b000000;
	localparam logic [5:0] OP_J = 6'b000010;
	localparam logic [5:0] OP_JAL = 6'b000011;
	localparam logic [5:0] OP_BEQ = 6'b000100;
	localparam logic [5:0] OP_BNE = 6'b000101;
	localparam logic [5:0] OP_ADDIU = 6'b001001;
	localparam logic [5:0] OP_SLTI = 6'b001010;
	localparam logic [5:0] OP_ANDI = 6'b001100;
	localparam logic [5:0] OP_ORI = 6'b001101;
	localparam logic [5:0] OP_LUI = 6'b001111;
	localparam logic [5:0] OP_LB = 6'b100000;
	localparam logic [5:0] OP_LW = 6'b100011;
	localparam logic [5:0] OP_LBU = 6'b100100;
	localparam logic [5:0] OP_SB = 6'b101000;
	localparam logic [5:0] OP_SW = 6'b101011;

	// funct field of special, inst[5:0]
	localparam logic [5:0] FN_SLL = 6'b000000;
	localparam logic [5:0] FN_SRL = 6'b000010;
	localparam logic [5:0] FN_SRA = 6'b000011;
	localparam logic [5:0] FN_JR = 6'b001000;
	localparam logic [5:0] FN_ADDU = 6'b100001;
	localparam logic [5:0] FN_SUBU = 6'b100011;
	localparam logic [5:0] FN_AND = 6'b100100;
	localparam logic [5:0] FN_OR = 6'b100101;
	localparam logic [5:0] FN_XOR = 6'b100110;
	localparam logic [5:0] FN_NOR = 6'b100111;
	localparam logic [5:0] FN_SLT = 6'b101010;
	localparam logic [5:0] FN_SLTU = 6'b101011;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
		ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
	} alu_op_t;

	typedef enum logic [1:0] {B_RT, B_SEXT, B_ZEXT} b_src_t;
	typedef enum logic [1:0] {WB_ALU, WB_LOAD, WB_LINK} wb_sel_t;
	typedef enum logic [1:0] {LD_WORD, LD_BYTE, LD_BYTEU} load_t;
	typedef enum logic [2:0] {BR_NONE, BR_BEQ, BR_BNE, BR_JUMP, BR_JR} branch_t;

	// decoded control, all zero is a nop
	typedef struct packed {
		alu_op_t alu_op;
		b_src_t b_src;
		logic shamt_a;
		wb_sel_t wb_sel;
		logic reg_write;
		logic rd_is_dst;
		logic link;
		logic mem_read;
		logic mem_write;
		logic byte_store;
		load_t load;
		branch_t branch;
	} ctrl_t;

	// instruction fields carried into ex
	typedef struct packed {
		word_t pc;
		reg_addr_t rs;
		reg_addr_t rt;
		reg_addr_t rd;
		logic [15:0] imm;
		logic [4:0] shamt;
		logic [25:0] jidx;
	} ex_in_t;

	// ex results carried into mem
	typedef struct packed {
		word_t pc;
		word_t result;
		word_t link;
		reg_addr_t rt;
		reg_addr_t rd;
	} mem_in_t;

	// one register file write
	typedef struct packed {
		logic wen;
		reg_addr_t waddr;
		word_t wdata;
		word_t pc;
	} wb_t;

endpackage

// ==== cpu_fetch.sv ====
`timescale 1ns/1ns

module cpu_fetch import cpu_pkg::*; (
	input logic clk,
	input logic resetn,
	input logic redirect,
	input word_t redirect_target,
	output word_t fetch_addr,
	output word_t id_pc
);

	// next fetch address
	// redirect comes from the branch in ex, id then holds its delay slot
	always_comb
	begin
		if (!resetn)
			fetch_addr = RESET_VECTOR;
		else if (redirect)
			fetch_addr = redirect_target;
		else
			fetch_addr = id_pc + 32'd4;
	end

	// pc of the word the sram returns next cycle
	// held one word below the vector in reset so the first
	// cycle after release fetches the vector again
	always_ff @(posedge clk)
	begin
		if (!resetn)
			id_pc <= RESET_VECTOR - 32'd4;
		else
			id_pc <= fetch_addr;
	end

endmodule

// ==== cpu_control.sv ====
`timescale 1ns/1ns

module cpu_control import cpu_pkg::*; (
	input logic clk,
	input logic resetn,
	input word_t inst,
	input word_t id_pc,
	input mem_in_t mem_next,
	output ctrl_t ex_ctrl,
	output logic ex_valid,
	output ex_in_t ex_in,
	output ctrl_t mem_ctrl,
	output logic mem_valid,
	output mem_in_t mem_in
);

	logic [5:0] opcode;
	logic [5:0] funct;
	ctrl_t id_ctrl;
	logic id_valid;

	assign opcode = inst[31:26];
	assign funct = inst[5:0];

	// id decode
	always_comb
	begin
		id_ctrl = '0;
		case (opcode)
			OP_SPECIAL:
			begin
				// r-type writes rd unless turned off below
				id_ctrl.reg_write = 1'b1;
				id_ctrl.rd_is_dst = 1'b1;
				case (funct)
					FN_ADDU: id_ctrl.alu_op = ALU_ADD;
					FN_SUBU: id_ctrl.alu_op = ALU_SUB;
					FN_AND: id_ctrl.alu_op = ALU_AND;
					FN_OR: id_ctrl.alu_op = ALU_OR;
					FN_XOR: id_ctrl.alu_op = ALU_XOR;
					FN_NOR: id_ctrl.alu_op = ALU_NOR;
					FN_SLT: id_ctrl.alu_op = ALU_SLT;
					FN_SLTU: id_ctrl.alu_op = ALU_SLTU;
					FN_SLL:
					begin
						id_ctrl.alu_op = ALU_SLL;
						id_ctrl.shamt_a = 1'b1;
					end
					FN_SRL:
					begin
						id_ctrl.alu_op = ALU_SRL;
						id_ctrl.shamt_a = 1'b1;
					end
					FN_SRA:
					begin
						id_ctrl.alu_op = ALU_SRA;
						id_ctrl.shamt_a = 1'b1;
					end
					FN_JR:
					begin
						id_ctrl.reg_write = 1'b0;
						id_ctrl.branch = BR_JR;
					end
					// unknown funct, no write
					default: id_ctrl.reg_write = 1'b0;
				endcase
			end
			OP_ADDIU:
			begin
				id_ctrl.reg_write = 1'b1;
				id_ctrl.b_src = B_SEXT;
			end
			OP_SLTI:
			begin
				id_ctrl.reg_write = 1'b1;
				id_ctrl.b_src = B_SEXT;
				id_ctrl.alu_op = ALU_SLT;
			end
			OP_ANDI:
			begin
				id_ctrl.reg_write = 1'b1;
				id_ctrl.b_src = B_ZEXT;
				id_ctrl.alu_op = ALU_AND;
			end
			OP_ORI:
			begin
				id_ctrl.reg_write = 1'b1;
				id_ctrl.b_src = B_ZEXT;
				id_ctrl.alu_op = ALU_OR;
			end
			OP_LUI:
			begin
				id_ctrl.reg_write = 1'b1;
				id_ctrl.b_src = B_ZEXT;
				id_ctrl.alu_op = ALU_LUI;
			end
			OP_LW, OP_LB, OP_LBU:
			begin
				// address is rs + sext(imm), data selected in mem
				id_ctrl.reg_write = 1'b1;
				id_ctrl.b_src = B_SEXT;
				id_ctrl.mem_read = 1'b1;
				id_ctrl.wb_sel = WB_LOAD;
				id_ctrl.load = (opcode == OP_LB) ? LD_BYTE :
					(opcode == OP_LBU) ? LD_BYTEU : LD_WORD;
			end
			OP_SW, OP_SB:
			begin
				id_ctrl.b_src = B_SEXT;
				id_ctrl.mem_write = 1'b1;
				id_ctrl.byte_store = (opcode == OP_SB);
			end
			OP_BEQ: id_ctrl.branch = BR_BEQ;
			OP_BNE: id_ctrl.branch = BR_BNE;
			OP_J: id_ctrl.branch = BR_JUMP;
			OP_JAL:
			begin
				// link goes to r31
				id_ctrl.branch = BR_JUMP;
				id_ctrl.reg_write = 1'b1;
				id_ctrl.link = 1'b1;
				id_ctrl.wb_sel = WB_LINK;
			end
			default: id_ctrl = '0;
		endcase
	end

	// stage valid bits, id slot in the first cycle after reset is stale
	always_ff @(posedge clk)
	begin
		if (!resetn)
		begin
			id_valid <= 1'b0;
			ex_valid <= 1'b0;
			mem_valid <= 1'b0;
		end
		else
		begin
			id_valid <= 1'b1;
			ex_valid <= id_valid;
			mem_valid <= ex_valid;
		end
	end

	// id/ex and ex/mem payload, qualified by the valid bits
	always_ff @(posedge clk)
	begin
		ex_ctrl <= id_ctrl;
		ex_in.pc <= id_pc;
		ex_in.rs <= inst[25:21];
		ex_in.rt <= inst[20:16];
		ex_in.rd <= inst[15:11];
		ex_in.imm <= inst[15:0];
		ex_in.shamt <= inst[10:6];
		ex_in.jidx <= inst[25:0];
		mem_ctrl <= ex_ctrl;
		mem_in <= mem_next;
	end

endmodule

// ==== cpu_regfile.sv ====
`timescale 1ns/1ns

module cpu_regfile import cpu_pkg::*; (
	input logic clk,
	input logic resetn,
	input reg_addr_t raddr1,
	input reg_addr_t raddr2,
	input wb_t wb,
	output word_t rdata1,
	output word_t rdata2
);

	// r0 entry never written
	word_t regs [32];

	// write at the end of the mem cycle
	always_ff @(posedge clk)
	begin
		if (resetn && wb.wen && wb.waddr != 5'd0)
			regs[wb.waddr] <= wb.wdata;
	end

	// async reads, r0 hardwired to zero
	assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1];
	assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : regs[raddr2];

endmodule

// ==== cpu_execute.sv ====
`timescale 1ns/1ns

module cpu_execute import cpu_pkg::*; (
	input ctrl_t ex_ctrl,
	input logic ex_valid,
	input ex_in_t ex_in,
	input word_t rdata1,
	input word_t rdata2,
	input wb_t wb,
	output mem_in_t mem_in,
	output logic redirect,
	output word_t redirect_target,
	output logic data_sram_en,
	output strb_t data_sram_wen,
	output word_t data_sram_addr,
	output word_t data_sram_wdata
);

	word_t rs_val;
	word_t rt_val;
	word_t op_a;
	word_t op_b;
	word_t result;
	word_t pc4;
	word_t br_target;
	word_t jump_target;
	logic fwd_rs;
	logic fwd_rt;
	logic taken;
	strb_t strb;

	// bypass from mem, covers load-use too since load data is there
	assign fwd_rs = wb.wen && wb.waddr != 5'd0 && wb.waddr == ex_in.rs;
	assign fwd_rt = wb.wen && wb.waddr != 5'd0 && wb.waddr == ex_in.rt;
	assign rs_val = fwd_rs ? wb.wdata : rdata1;
	assign rt_val = fwd_rt ? wb.wdata : rdata2;

	// shifts take the amount from the instruction
	assign op_a = ex_ctrl.shamt_a ? {27'd0, ex_in.shamt} : rs_val;

	always_comb
	begin
		case (ex_ctrl.b_src)
			B_SEXT: op_b = {{16{ex_in.imm[15]}}, ex_in.imm};
			B_ZEXT: op_b = {16'd0, ex_in.imm};
			default: op_b = rt_val;
		endcase
	end

	// alu
	always_comb
	begin
		case (ex_ctrl.alu_op)
			ALU_ADD: result = op_a + op_b;
			ALU_SUB: result = op_a - op_b;
			ALU_AND: result = op_a & op_b;
			ALU_OR: result = op_a | op_b;
			ALU_XOR: result = op_a ^ op_b;
			ALU_NOR: result = ~(op_a | op_b);
			ALU_SLT: result = {31'd0, $signed(op_a) < $signed(op_b)};
			ALU_SLTU: result = {31'd0, op_a < op_b};
			ALU_SLL: result = op_b << op_a[4:0];
			ALU_SRL: result = op_b >> op_a[4:0];
			ALU_SRA: result = $signed(op_b) >>> op_a[4:0];
			ALU_LUI: result = {op_b[15:0], 16'd0};
			default: result = op_a + op_b;
		endcase
	end

	// branch targets are relative to the delay slot
	assign pc4 = ex_in.pc + 32'd4;
	assign br_target = pc4 + {{14{ex_in.imm[15]}}, ex_in.imm, 2'b00};
	assign jump_target = {pc4[31:28], ex_in.jidx, 2'b00};

	always_comb
	begin
		taken = 1'b0;
		redirect_target = br_target;
		case (ex_ctrl.branch)
			BR_BEQ: taken = (rs_val == rt_val);
			BR_BNE: taken = (rs_val != rt_val);
			BR_JUMP:
			begin
				taken = 1'b1;
				redirect_target = jump_target;
			end
			BR_JR:
			begin
				taken = 1'b1;
				redirect_target = rs_val;
			end
			default: taken = 1'b0;
		endcase
	end

	assign redirect = ex_valid & taken;

	// sb puts the byte on every lane, strobe picks one
	always_comb
	begin
		if (ex_ctrl.byte_store)
		begin
			strb = 4'b0001 << result[1:0];
			data_sram_wdata = {4{rt_val[7:0]}};
		end
		else
		begin
			strb = 4'b1111;
			data_sram_wdata = rt_val;
		end
	end

	// sram sees the address in ex, read data is back in mem
	assign data_sram_en = ex_valid & (ex_ctrl.mem_read | ex_ctrl.mem_write);
	assign data_sram_wen = (ex_valid & ex_ctrl.mem_write) ? strb : 4'b0000;
	assign data_sram_addr = result;

	// payload for mem
	assign mem_in.pc = ex_in.pc;
	assign mem_in.result = result;
	assign mem_in.link = ex_in.pc + 32'd8;
	assign mem_in.rt = ex_in.rt;
	assign mem_in.rd = ex_in.rd;

endmodule

// ==== cpu_writeback.sv ====
`timescale 1ns/1ns

module cpu_writeback import cpu_pkg::*; (
	input ctrl_t mem_ctrl,
	input logic mem_valid,
	input mem_in_t mem_in,
	input word_t data_sram_rdata,
	output wb_t wb
);

	logic [7:0] load_byte;
	word_t load_data;

	// lane from the low address bits
	assign load_byte = data_sram_rdata[8 * mem_in.result[1:0] +: 8];

	always_comb
	begin
		case (mem_ctrl.load)
			LD_BYTE: load_data = {{24{load_byte[7]}}, load_byte};
			LD_BYTEU: load_data = {24'd0, load_byte};
			default: load_data = data_sram_rdata;
		endcase
	end

	// jal to r31, r-type to rd, rest to rt
	assign wb.waddr = mem_ctrl.link ? REG_RA : (mem_ctrl.rd_is_dst ? mem_in.rd : mem_in.rt);
	assign wb.wen = mem_valid & mem_ctrl.reg_write;
	assign wb.pc = mem_in.pc;

	always_comb
	begin
		case (mem_ctrl.wb_sel)
			WB_LOAD: wb.wdata = load_data;
			WB_LINK: wb.wdata = mem_in.link;
			default: wb.wdata = mem_in.result;
		endcase
	end

endmodule

// ==== cpu_top.sv ====
`timescale 1ns/1ns

module cpu_top import cpu_pkg::*; (
	input logic clk,
	input logic resetn,
	output logic inst_sram_en,
	output strb_t inst_sram_wen,
	output word_t inst_sram_addr,
	output word_t inst_sram_wdata,
	input word_t inst_sram_rdata,
	output logic data_sram_en,
	output strb_t data_sram_wen,
	output word_t data_sram_addr,
	output word_t data_sram_wdata,
	input word_t data_sram_rdata,
	output word_t debug_wb_pc,
	output strb_t debug_wb_rf_wen,
	output reg_addr_t debug_wb_rf_wnum,
	output word_t debug_wb_rf_wdata
);

	word_t id_pc;
	logic redirect;
	word_t redirect_target;
	ctrl_t ex_ctrl;
	ctrl_t mem_ctrl;
	logic ex_valid;
	logic mem_valid;
	ex_in_t ex_in;
	mem_in_t mem_next;
	mem_in_t mem_in;
	word_t rdata1;
	word_t rdata2;
	wb_t wb;

	// fetch every cycle, never write the instruction sram
	assign inst_sram_en = 1'b1;
	assign inst_sram_wen = 4'b0000;
	assign inst_sram_wdata = 32'd0;

	cpu_fetch u_fetch (
		.clk(clk),
		.resetn(resetn),
		.redirect(redirect),
		.redirect_target(redirect_target),
		.fetch_addr(inst_sram_addr),
		.id_pc(id_pc)
	);

	cpu_control u_control (
		.clk(clk),
		.resetn(resetn),
		.inst(inst_sram_rdata),
		.id_pc(id_pc),
		.mem_next(mem_next),
		.ex_ctrl(ex_ctrl),
		.ex_valid(ex_valid),
		.ex_in(ex_in),
		.mem_ctrl(mem_ctrl),
		.mem_valid(mem_valid),
		.mem_in(mem_in)
	);

	// register reads happen in ex
	cpu_regfile u_regfile (
		.clk(clk),
		.resetn(resetn),
		.raddr1(ex_in.rs),
		.raddr2(ex_in.rt),
		.wb(wb),
		.rdata1(rdata1),
		.rdata2(rdata2)
	);

	cpu_execute u_execute (
		.ex_ctrl(ex_ctrl),
		.ex_valid(ex_valid),
		.ex_in(ex_in),
		.rdata1(rdata1),
		.rdata2(rdata2),
		.wb(wb),
		.mem_in(mem_next),
		.redirect(redirect),
		.redirect_target(redirect_target),
		.data_sram_en(data_sram_en),
		.data_sram_wen(data_sram_wen),
		.data_sram_addr(data_sram_addr),
		.data_sram_wdata(data_sram_wdata)
	);

	cpu_writeback u_writeback (
		.mem_ctrl(mem_ctrl),
		.mem_valid(mem_valid),
		.mem_in(mem_in),
		.data_sram_rdata(data_sram_rdata),
		.wb(wb)
	);

	// debug trace, one cycle after the regfile write
	// writes to r0 do not show
	always_ff @(posedge clk)
	begin
		if (!resetn)
			debug_wb_rf_wen <= 4'b0000;
		else if (wb.wen && wb.waddr != 5'd0)
			debug_wb_rf_wen <= 4'b1111;
		else
			debug_wb_rf_wen <= 4'b0000;
	end

	// trace payload, only meaningful with wen set
	always_ff @(posedge clk)
	begin
		if (wb.wen && wb.waddr != 5'd0)
		begin
			debug_wb_pc <= wb.pc;
			debug_wb_rf_wnum <= wb.waddr;
			debug_wb_rf_wdata <= wb.wdata;
		end
	end

endmodule

// ==== cpu_tb_clock.sv ====
`timescale 1ns/1ns

module cpu_tb_clock (
	input logic reset_req,
	output logic clk,
	output logic resetn
);

	int unsigned hold;
	logic req;

	initial
	begin
		clk = 1'b0;
		resetn = 1'b0;
		hold = 2;
	end

	// 100 ns period
	always #50 clk = ~clk;

	// request seen at the edge, resetn moves 10 ns later
	always @(posedge clk)
	begin
		req = reset_req;
		#10;
		if (req)
			hold = 3;
		if (hold != 0)
		begin
			resetn = 1'b0;
			hold = hold - 1;
		end
		else
			resetn = 1'b1;
	end

endmodule

// ==== cpu_top_assert.sv ====
`timescale 1ns/1ns

module cpu_top_assert import cpu_pkg::*; (
	input logic clk,
	input logic resetn,
	input logic data_sram_en,
	input strb_t data_sram_wen,
	input strb_t inst_sram_wen,
	input strb_t debug_wb_rf_wen
);

	// a data write must come with the enable
	assert property (@(posedge clk) disable iff (!resetn) (data_sram_wen != 4'b0000) |-> data_sram_en)
		else $error("data sram strobe without enable");

	// instruction sram is read only
	assert property (@(posedge clk) inst_sram_wen == 4'b0000)
		else $error("instruction sram write strobe set");

	// trace is quiet right after a reset cycle
	assert property (@(posedge clk) !resetn |=> debug_wb_rf_wen == 4'b0000)
		else $error("debug wen set after reset cycle");

endmodule

bind cpu_top cpu_top_assert u_assert (
	.clk(clk),
	.resetn(resetn),
	.data_sram_en(data_sram_en),
	.data_sram_wen(data_sram_wen),
	.inst_sram_wen(inst_sram_wen),
	.debug_wb_rf_wen(debug_wb_rf_wen)
);

// ==== cpu_tb.sv ====
`timescale 1ns/1ns

module cpu_tb import cpu_pkg::*; ();

	// cycle budget of each test, watchdog gets twice the sum
	localparam int TASK_BUDGET = 60;
	localparam int NUM_TASKS = 5;
	localparam int DMEM_WORDS = 256;

	logic clk;
	logic resetn;
	logic reset_req;
	logic inst_sram_en;
	strb_t inst_sram_wen;
	word_t inst_sram_addr;
	word_t inst_sram_wdata;
	word_t inst_sram_rdata;
	logic data_sram_en;
	strb_t data_sram_wen;
	word_t data_sram_addr;
	word_t data_sram_wdata;
	word_t data_sram_rdata;
	word_t debug_wb_pc;
	strb_t debug_wb_rf_wen;
	reg_addr_t debug_wb_rf_wnum;
	word_t debug_wb_rf_wdata;

	word_t imem [1024];
	word_t dmem [DMEM_WORDS];
	int prog_len;
	logic [31:0] lfsr;

	// observed and expected trace
	word_t trace_pc [$];
	reg_addr_t trace_num [$];
	word_t trace_data [$];
	strb_t trace_strb [$];
	word_t exp_pc [$];
	reg_addr_t exp_num [$];
	word_t exp_data [$];
	strb_t exp_strb [$];

	cpu_tb_clock u_clock (
		.reset_req(reset_req),
		.clk(clk),
		.resetn(resetn)
	);

	cpu_top uut (
		.clk(clk),
		.resetn(resetn),
		.inst_sram_en(inst_sram_en),
		.inst_sram_wen(inst_sram_wen),
		.inst_sram_addr(inst_sram_addr),
		.inst_sram_wdata(inst_sram_wdata),
		.inst_sram_rdata(inst_sram_rdata),
		.data_sram_en(data_sram_en),
		.data_sram_wen(data_sram_wen),
		.data_sram_addr(data_sram_addr),
		.data_sram_wdata(data_sram_wdata),
		.data_sram_rdata(data_sram_rdata),
		.debug_wb_pc(debug_wb_pc),
		.debug_wb_rf_wen(debug_wb_rf_wen),
		.debug_wb_rf_wnum(debug_wb_rf_wnum),
		.debug_wb_rf_wdata(debug_wb_rf_wdata)
	);

	// data word after reset, mixes every index bit
	function automatic word_t fill_word(int idx);
		word_t a;
		a = idx * 4;
		return (a * 32'h9e37_79b1) ^ {a[15:0], ~a[15:0]};
	endfunction

	// instruction sram, one cycle read
	always @(posedge clk)
	begin
		if (inst_sram_en)
			inst_sram_rdata <= imem[inst_sram_addr[11:2]];
	end

	// data sram, refilled while in reset
	always @(posedge clk)
	begin
		if (!resetn)
		begin
			for (int i = 0; i < DMEM_WORDS; i++)
				dmem[i] <= fill_word(i);
		end
		else if (data_sram_en)
		begin
			data_sram_rdata <= dmem[data_sram_addr[9:2]];
			for (int b = 0; b < 4; b++)
				if (data_sram_wen[b])
					dmem[data_sram_addr[9:2]][8 * b +: 8] <= data_sram_wdata[8 * b +: 8];
		end
	end

	// trace and strobes sampled mid cycle
	always @(negedge clk)
	begin
		if (resetn && debug_wb_rf_wen != 4'b0000)
		begin
			// a register write shows on all four lanes
			check_strb("debug_wb_rf_wen", debug_wb_rf_wen, 4'b1111);
			trace_pc.push_back(debug_wb_pc);
			trace_num.push_back(debug_wb_rf_wnum);
			trace_data.push_back(debug_wb_rf_wdata);
		end
		if (resetn && data_sram_wen != 4'b0000)
			trace_strb.push_back(data_sram_wen);
	end

	// galois lfsr, one step per bit
	function automatic word_t rand_bits(int n);
		word_t v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return v;
	endfunction

	task automatic stop_on_failure();
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic fail_run(string why);
		$display("%s", why);
		stop_on_failure();
	endtask

	task automatic check_word(string name, word_t got, word_t exp);
		if (got !== exp)
		begin
			$display("** Error %s got %h expected %h", name, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic check_reg(string name, reg_addr_t got, reg_addr_t exp);
		if (got !== exp)
		begin
			$display("** Error %s got %h expected %h", name, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic check_strb(string name, strb_t got, strb_t exp);
		if (got !== exp)
		begin
			$display("** Error %s got %h expected %h", name, got, exp);
			stop_on_failure();
		end
	endtask

	// hand assembler
	function automatic word_t rtype(reg_addr_t rs, reg_addr_t rt, reg_addr_t rd,
		logic [4:0] sh, logic [5:0] fn);
		return {OP_SPECIAL, rs, rt, rd, sh, fn};
	endfunction

	function automatic word_t itype(logic [5:0] op, reg_addr_t rs, reg_addr_t rt,
		logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t pc_at(int idx);
		return RESET_VECTOR + idx * 4;
	endfunction

	function automatic word_t jtype(logic [5:0] op, int idx);
		word_t target;
		target = pc_at(idx);
		return {op, target[27:2]};
	endfunction

	task automatic put(word_t inst);
		imem[prog_len] = inst;
		prog_len++;
	endtask

	task automatic expect_write(int idx, reg_addr_t num, word_t data);
		exp_pc.push_back(pc_at(idx));
		exp_num.push_back(num);
		exp_data.push_back(data);
	endtask

	// next instruction writes num
	task automatic put_w(word_t inst, reg_addr_t num, word_t data);
		expect_write(prog_len, num, data);
		put(inst);
	endtask

	// hold the core in reset, then load a fresh program
	task automatic begin_program();
		@(posedge clk);
		#10 reset_req = 1'b1;
		@(posedge clk);
		#10 reset_req = 1'b0;
		wait (!resetn);
		for (int i = 0; i < 1024; i++)
			imem[i] = 32'd0;
		prog_len = 0;
		trace_pc.delete();
		trace_num.delete();
		trace_data.delete();
		trace_strb.delete();
		exp_pc.delete();
		exp_num.delete();
		exp_data.delete();
		exp_strb.delete();
	endtask

	// park in a j-to-self loop and compare the trace
	task automatic finish_program();
		int waited;
		int self_idx;
		self_idx = prog_len;
		put(jtype(OP_J, self_idx));
		put(32'd0);
		wait (resetn);
		waited = 0;
		while (trace_pc.size() < exp_pc.size() && waited < TASK_BUDGET)
		begin
			@(posedge clk);
			waited++;
		end
		if (trace_pc.size() < exp_pc.size())
			fail_run("register trace ended before all expected writes");
		repeat (8) @(posedge clk);
		if (trace_pc.size() != exp_pc.size())
			fail_run("unexpected extra register write in trace");
		if (trace_strb.size() != exp_strb.size())
			fail_run("wrong number of data sram stores");
		for (int i = 0; i < exp_pc.size(); i++)
		begin
			check_word("debug_wb_pc", trace_pc[i], exp_pc[i]);
			check_reg("debug_wb_rf_wnum", trace_num[i], exp_num[i]);
			check_word("debug_wb_rf_wdata", trace_data[i], exp_data[i]);
		end
		for (int i = 0; i < exp_strb.size(); i++)
			check_strb("data_sram_wen", trace_strb[i], exp_strb[i]);
	endtask

	task automatic reset_start_trace();
		begin_program();
		put_w(itype(OP_ADDIU, 5'd0, 5'd1, 16'h0005), 5'd1, 32'd5);
		put_w(itype(OP_ADDIU, 5'd1, 5'd2, 16'hffff), 5'd2, 32'd4);
		wait (resetn);
		// trace still quiet just after release
		@(negedge clk);
		check_strb("debug_wb_rf_wen", debug_wb_rf_wen, 4'b0000);
		finish_program();
	endtask

	task automatic alu_results();
		word_t a;
		word_t b;
		word_t r;
		logic [4:0] sh;
		logic [15:0] imm;
		a = rand_bits(32);
		b = rand_bits(32);
		r = rand_bits(5);
		sh = r[4:0];
		r = rand_bits(16);
		imm = r[15:0];
		begin_program();
		put_w(itype(OP_LUI, 5'd0, 5'd1, a[31:16]), 5'd1, {a[31:16], 16'd0});
		put_w(itype(OP_ORI, 5'd1, 5'd1, a[15:0]), 5'd1, a);
		put_w(itype(OP_LUI, 5'd0, 5'd2, b[31:16]), 5'd2, {b[31:16], 16'd0});
		put_w(itype(OP_ORI, 5'd2, 5'd2, b[15:0]), 5'd2, b);
		put_w(rtype(5'd1, 5'd2, 5'd3, 5'd0, FN_ADDU), 5'd3, a + b);
		put_w(rtype(5'd1, 5'd2, 5'd4, 5'd0, FN_SUBU), 5'd4, a - b);
		put_w(rtype(5'd1, 5'd2, 5'd5, 5'd0, FN_AND), 5'd5, a & b);
		put_w(rtype(5'd1, 5'd2, 5'd6, 5'd0, FN_OR), 5'd6, a | b);
		put_w(rtype(5'd1, 5'd2, 5'd7, 5'd0, FN_XOR), 5'd7, a ^ b);
		put_w(rtype(5'd1, 5'd2, 5'd8, 5'd0, FN_NOR), 5'd8, ~(a | b));
		put_w(rtype(5'd1, 5'd2, 5'd9, 5'd0, FN_SLT), 5'd9, {31'd0, $signed(a) < $signed(b)});
		put_w(rtype(5'd1, 5'd2, 5'd10, 5'd0, FN_SLTU), 5'd10, {31'd0, a < b});
		put_w(rtype(5'd0, 5'd2, 5'd11, sh, FN_SLL), 5'd11, b << sh);
		put_w(rtype(5'd0, 5'd2, 5'd12, sh, FN_SRL), 5'd12, b >> sh);
		put_w(rtype(5'd0, 5'd2, 5'd13, sh, FN_SRA), 5'd13, $signed(b) >>> sh);
		put_w(itype(OP_ADDIU, 5'd1, 5'd14, imm), 5'd14, a + {{16{imm[15]}}, imm});
		put_w(itype(OP_ANDI, 5'd1, 5'd15, imm), 5'd15, a & {16'd0, imm});
		put_w(itype(OP_SLTI, 5'd1, 5'd16, imm), 5'd16,
			{31'd0, $signed(a) < $signed({{16{imm[15]}}, imm})});
		finish_program();
	endtask

	task automatic forwarding_paths();
		word_t r;
		logic [15:0] x;
		word_t v1;
		word_t v4;
		r = rand_bits(16);
		x = r[15:0];
		v1 = {{16{x[15]}}, x};
		v4 = (v1 + v1 + v1) - (v1 + v1);
		begin_program();
		// each result used by the very next instruction
		put_w(itype(OP_ADDIU, 5'd0, 5'd1, x), 5'd1, v1);
		put_w(rtype(5'd1, 5'd1, 5'd2, 5'd0, FN_ADDU), 5'd2, v1 + v1);
		put_w(rtype(5'd2, 5'd1, 5'd3, 5'd0, FN_ADDU), 5'd3, v1 + v1 + v1);
		put_w(rtype(5'd3, 5'd2, 5'd4, 5'd0, FN_SUBU), 5'd4, v4);
		put(itype(OP_SW, 5'd0, 5'd4, 16'h0040));
		exp_strb.push_back(4'b1111);
		put_w(itype(OP_LW, 5'd0, 5'd5, 16'h0040), 5'd5, v4);
		// load then use
		put_w(rtype(5'd5, 5'd5, 5'd6, 5'd0, FN_ADDU), 5'd6, v4 + v4);
		finish_program();
	endtask

	task automatic load_store_lanes();
		word_t w;
		word_t w84;
		w = rand_bits(32);
		w[7] = 1'b1;
		w84 = fill_word(32'h84 >> 2);
		w84[15:8] = w[7:0];
		begin_program();
		put_w(itype(OP_LUI, 5'd0, 5'd1, w[31:16]), 5'd1, {w[31:16], 16'd0});
		put_w(itype(OP_ORI, 5'd1, 5'd1, w[15:0]), 5'd1, w);
		put(itype(OP_SW, 5'd0, 5'd1, 16'h0080));
		exp_strb.push_back(4'b1111);
		put(itype(OP_SB, 5'd0, 5'd1, 16'h0085));
		exp_strb.push_back(4'b0010);
		put_w(itype(OP_LW, 5'd0, 5'd2, 16'h0080), 5'd2, w);
		put_w(itype(OP_LB, 5'd0, 5'd3, 16'h0085), 5'd3, {{24{w[7]}}, w[7:0]});
		put_w(itype(OP_LBU, 5'd0, 5'd4, 16'h0085), 5'd4, {24'd0, w[7:0]});
		put_w(itype(OP_LB, 5'd0, 5'd5, 16'h0083), 5'd5, {{24{w[31]}}, w[31:24]});
		put_w(itype(OP_LBU, 5'd0, 5'd6, 16'h0083), 5'd6, {24'd0, w[31:24]});
		finish_program();
		check_word("dmem[0x80]", dmem[32'h80 >> 2], w);
		check_word("dmem[0x84]", dmem[32'h84 >> 2], w84);
	endtask

	task automatic branch_delay_slots();
		begin_program();
		put(itype(OP_ADDIU, 5'd0, 5'd1, 16'd7));
		put(itype(OP_ADDIU, 5'd0, 5'd2, 16'd7));
		put(itype(OP_BEQ, 5'd1, 5'd2, 16'd2));
		put(itype(OP_ADDIU, 5'd0, 5'd3, 16'd1));
		put(itype(OP_ADDIU, 5'd0, 5'd4, 16'd2));
		put(itype(OP_BNE, 5'd1, 5'd2, 16'd2));
		put(itype(OP_ADDIU, 5'd0, 5'd5, 16'd3));
		put(itype(OP_ADDIU, 5'd0, 5'd6, 16'd4));
		put(jtype(OP_JAL, 14));
		put(itype(OP_ADDIU, 5'd0, 5'd7, 16'd5));
		// return point of jr
		put(itype(OP_ADDIU, 5'd0, 5'd8, 16'd6));
		put(jtype(OP_J, 17));
		put(itype(OP_ADDIU, 5'd0, 5'd10, 16'd9));
		put(itype(OP_ADDIU, 5'd0, 5'd11, 16'd10));
		put(rtype(REG_RA, 5'd0, 5'd0, 5'd0, FN_JR));
		put(itype(OP_ADDIU, 5'd0, 5'd9, 16'd8));
		put(itype(OP_ADDIU, 5'd0, 5'd12, 16'd12));
		put(itype(OP_BNE, 5'd1, 5'd0, 16'd2));
		put(itype(OP_ADDIU, 5'd0, 5'd13, 16'd11));
		put(itype(OP_ADDIU, 5'd0, 5'd14, 16'd13));
		put(itype(OP_BEQ, 5'd1, 5'd0, 16'd2));
		put(itype(OP_ADDIU, 5'd0, 5'd15, 16'd14));
		put(itype(OP_ADDIU, 5'd0, 5'd16, 16'd15));
		// trace order follows the taken paths
		expect_write(0, 5'd1, 32'd7);
		expect_write(1, 5'd2, 32'd7);
		expect_write(3, 5'd3, 32'd1);
		expect_write(6, 5'd5, 32'd3);
		expect_write(7, 5'd6, 32'd4);
		expect_write(8, REG_RA, pc_at(10));
		expect_write(9, 5'd7, 32'd5);
		expect_write(15, 5'd9, 32'd8);
		expect_write(10, 5'd8, 32'd6);
		expect_write(12, 5'd10, 32'd9);
		// taken bne skips idx 19, untaken beq falls through
		expect_write(18, 5'd13, 32'd11);
		expect_write(21, 5'd15, 32'd14);
		expect_write(22, 5'd16, 32'd15);
		finish_program();
	endtask

	initial
	begin
		reset_req = 1'b0;
		inst_sram_rdata = 32'd0;
		data_sram_rdata = 32'd0;
		lfsr = 32'd75839;
		prog_len = 0;
		reset_start_trace();
		alu_results();
		forwarding_paths();
		load_store_lanes();
		branch_delay_slots();
		$display("all tests passed");
		$finish;
	end

	// watchdog
	initial
	begin
		#(TASK_BUDGET * NUM_TASKS * 100 * 2);
		fail_run("timeout: program did not finish");
	end

endmodule

// ==== cpu_top.f ====
cpu_pkg.sv
cpu_fetch.sv
cpu_control.sv
cpu_regfile.sv
cpu_execute.sv
cpu_writeback.sv
cpu_top.sv
cpu_tb_clock.sv
cpu_top_assert.sv
cpu_tb.sv

// ==== Makefile ====
SRCS = cpu_pkg.sv cpu_fetch.sv cpu_control.sv cpu_regfile.sv cpu_execute.sv \
	cpu_writeback.sv cpu_top.sv cpu_tb_clock.sv cpu_top_assert.sv cpu_tb.sv

.PHONY: run clean

run: obj_dir/Vcpu_tb
	./obj_dir/Vcpu_tb

obj_dir/Vcpu_tb: $(SRCS) cpu_top.f
	verilator --binary --timing --assert --top-module cpu_tb -f cpu_top.f

clean:
	rm -rf obj_dir
